// ==== Makefile ====
# Verilator build and run for the integer core slice

TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = int_core_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src/core_ifs.sv ====
/*
  Register read and writeback bundles between the stages.
  Read data is combinational, with no handshake on either bundle.
*/
`timescale 1ns/1ps

interface reg_read_if;
  import isa_pkg::*;

  reg_index_t rs1_index;
  reg_index_t rs2_index;
  xlen_t      rs1_data;
  xlen_t      rs2_data;

  modport master (output rs1_index, rs2_index, input rs1_data, rs2_data);
  modport slave (input rs1_index, rs2_index, output rs1_data, rs2_data);
endinterface

interface writeback_if;
  import isa_pkg::*;

  logic       valid;
  logic       illegal;
  reg_index_t rd;
  xlen_t      data;
  // valid with a non-zero rd
  logic       write_enable;

  modport source (output valid, illegal, rd, data, write_enable);
  modport sink (input valid, illegal, rd, data, write_enable);
endinterface

// ==== src/core_params.svh ====
/*
  Sizing constants for the integer core slice.
  Only XLEN=32 is supported by the decoder and ALU.
*/
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width
`define XLEN 32

// architectural integer registers, x0 included
`define REG_COUNT 32

// must cover REG_COUNT
`define REG_INDEX_BITS 5

`endif

// ==== src/core_pkg.sv ====
/*
  Micro-op format passed from decode to execute.
  Fields are only meaningful while valid is set.
*/
package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_IMM   // lui
  } alu_op_t;

  typedef struct packed {
    logic                valid;
    logic                illegal;
    alu_op_t             alu_op;
    isa_pkg::reg_index_t rs1;
    isa_pkg::reg_index_t rs2;
    isa_pkg::reg_index_t rd;
    logic                use_imm;
    isa_pkg::xlen_t      imm;
    // cleared for x0 and for anything not valid
    logic                rd_valid;
  } micro_op_t;

endpackage

// ==== src/decode_stage.sv ====
/*
  One-cycle decoder for the RV32I ALU subset and lui.
  Anything else, including unused funct7 bits, comes out as illegal.
*/
`timescale 1ns/1ps

module decode_stage (
  input  logic                clock,
  input  logic                reset,
  input  isa_pkg::inst_t      inst,
  input  logic                inst_valid,
  output core_pkg::micro_op_t uop
);
  import isa_pkg::*;
  import core_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  micro_op_t  next_uop;
  logic       supported;

  assign opcode = opcode_t'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    next_uop         = '0;
    supported        = 1'b1;
    next_uop.alu_op  = ALU_ADD;
    next_uop.rs1     = inst[19:15];
    next_uop.rs2     = inst[24:20];
    next_uop.rd      = inst[11:7];
    next_uop.imm     = xlen_t'($signed(inst[31:20]));
    case (opcode)
      OPC_OP: begin
        if (funct7 == FUNCT7_BASE) begin
          case (funct3)
            FUNCT3_ADD_SUB: next_uop.alu_op = ALU_ADD;
            FUNCT3_SLL:     next_uop.alu_op = ALU_SLL;
            FUNCT3_SLT:     next_uop.alu_op = ALU_SLT;
            FUNCT3_SLTU:    next_uop.alu_op = ALU_SLTU;
            FUNCT3_XOR:     next_uop.alu_op = ALU_XOR;
            FUNCT3_SRL_SRA: next_uop.alu_op = ALU_SRL;
            FUNCT3_OR:      next_uop.alu_op = ALU_OR;
            default:        next_uop.alu_op = ALU_AND;
          endcase
        end else if (funct7 == FUNCT7_ALT && funct3 == FUNCT3_ADD_SUB) begin
          next_uop.alu_op = ALU_SUB;
        end else if (funct7 == FUNCT7_ALT && funct3 == FUNCT3_SRL_SRA) begin
          next_uop.alu_op = ALU_SRA;
        end else begin
          supported = 1'b0;
        end
      end
      OPC_OP_IMM: begin
        next_uop.use_imm = 1'b1;
        case (funct3)
          FUNCT3_ADD_SUB: next_uop.alu_op = ALU_ADD;
          FUNCT3_SLT:     next_uop.alu_op = ALU_SLT;
          FUNCT3_SLTU:    next_uop.alu_op = ALU_SLTU;
          FUNCT3_XOR:     next_uop.alu_op = ALU_XOR;
          FUNCT3_OR:      next_uop.alu_op = ALU_OR;
          FUNCT3_AND:     next_uop.alu_op = ALU_AND;
          FUNCT3_SLL: begin
            next_uop.alu_op = ALU_SLL;
            next_uop.imm    = xlen_t'(inst[24:20]);
            supported       = (funct7 == FUNCT7_BASE);
          end
          default: begin
            // srli / srai share funct3, shamt in the rs2 slot
            next_uop.alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
            next_uop.imm    = xlen_t'(inst[24:20]);
            supported       = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
          end
        endcase
      end
      OPC_LUI: begin
        next_uop.alu_op  = ALU_PASS_IMM;
        next_uop.use_imm = 1'b1;
        next_uop.imm     = xlen_t'({inst[31:12], 12'b0});
      end
      default: supported = 1'b0;
    endcase
    next_uop.valid    = inst_valid && supported;
    next_uop.illegal  = inst_valid && !supported;
    next_uop.rd_valid = next_uop.valid && (next_uop.rd != '0);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      uop <= '0;
    end else begin
      uop <= next_uop;
    end
  end

  a_valid_xor_illegal: assert property (
    @(posedge clock) disable iff (reset) !(uop.valid && uop.illegal)
  ) else $error("micro-op marked both valid and illegal");

endmodule

// ==== src/execute_stage.sv ====
/*
  ALU stage, operands read combinationally through the register port.
  Result and retire flags are registered, one cycle after the micro-op.
*/
`timescale 1ns/1ps

module execute_stage (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::micro_op_t uop,
  reg_read_if.master          rd_port,
  writeback_if.source         wb
);
  import isa_pkg::*;
  import core_pkg::*;

  xlen_t      op_a;
  xlen_t      op_b;
  xlen_t      result;
  logic [4:0] shamt;

  assign rd_port.rs1_index = uop.rs1;
  assign rd_port.rs2_index = uop.rs2;

  assign op_a  = rd_port.rs1_data;
  assign op_b  = uop.use_imm ? uop.imm : rd_port.rs2_data;
  // upper bits of the shift amount are ignored
  assign shamt = op_b[4:0];

  always_comb begin
    case (uop.alu_op)
      ALU_ADD:      result = op_a + op_b;
      ALU_SUB:      result = op_a - op_b;
      ALU_SLL:      result = op_a << shamt;
      ALU_SLT:      result = xlen_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:     result = xlen_t'(op_a < op_b);
      ALU_XOR:      result = op_a ^ op_b;
      ALU_SRL:      result = op_a >> shamt;
      ALU_SRA:      result = xlen_t'($signed(op_a) >>> shamt);
      ALU_OR:       result = op_a | op_b;
      ALU_AND:      result = op_a & op_b;
      ALU_PASS_IMM: result = uop.imm;
      default:      result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb.valid        <= 1'b0;
      wb.illegal      <= 1'b0;
      wb.write_enable <= 1'b0;
    end else begin
      wb.valid        <= uop.valid;
      wb.illegal      <= uop.illegal;
      wb.write_enable <= uop.valid && uop.rd_valid;
    end
  end

  // payload, qualified by the flags above
  always_ff @(posedge clock) begin
    wb.rd   <= uop.rd;
    wb.data <= result;
  end

  a_write_needs_valid: assert property (
    @(posedge clock) disable iff (reset) wb.write_enable |-> wb.valid && !wb.illegal
  ) else $error("register write from a retirement that is not valid");

endmodule

// ==== src/int_core.sv ====
/*
  Three-stage RV32I integer slice with no stall or back-pressure.
  Accepts one instruction per cycle; retire ports follow the
  input by two clock edges.
*/
`timescale 1ns/1ps

module int_core (
  input  logic                clock,
  input  logic                reset,
  input  isa_pkg::inst_t      inst,
  input  logic                inst_valid,
  output logic                retire_valid,
  output logic                retire_illegal,
  output isa_pkg::reg_index_t retire_rd,
  output isa_pkg::xlen_t      retire_data
);
  import core_pkg::*;

  micro_op_t uop;

  reg_read_if  rf_read ();
  writeback_if wb_bus ();

  decode_stage u_decode (
    .clock      (clock),
    .reset      (reset),
    .inst       (inst),
    .inst_valid (inst_valid),
    .uop        (uop)
  );

  execute_stage u_execute (
    .clock   (clock),
    .reset   (reset),
    .uop     (uop),
    .rd_port (rf_read.master),
    .wb      (wb_bus.source)
  );

  result_stage u_result (
    .clock   (clock),
    .reset   (reset),
    .rd_port (rf_read.slave),
    .wb      (wb_bus.sink)
  );

  // retire straight from the writeback register
  assign retire_valid   = wb_bus.valid;
  assign retire_illegal = wb_bus.illegal;
  assign retire_rd      = wb_bus.rd;
  assign retire_data    = wb_bus.data;

endmodule

// ==== src/isa_pkg.sv ====
/*
  RV32I encoding types and constants for the ALU subset only.
  Other opcodes are listed nowhere and decode as illegal.
*/
`include "core_params.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0]           xlen_t;
  typedef logic [`REG_INDEX_BITS-1:0] reg_index_t;
  typedef logic [31:0]                inst_t;

  // major opcodes handled by the slice
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_t;

  // funct3 of the ALU group, shared by OP and OP_IMM
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  // alt form selects sub and sra
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage

// ==== src/result_stage.sv ====
/*
  Integer register file, x0 hardwired to zero.
  Read ports forward the pending writeback, so a result is visible
  the cycle before it is written.
*/
`timescale 1ns/1ps
`include "core_params.svh"

module result_stage (
  input  logic      clock,
  input  logic      reset,
  reg_read_if.slave rd_port,
  writeback_if.sink wb
);
  import isa_pkg::*;

  xlen_t regs [1:`REG_COUNT-1];

  function automatic xlen_t read_reg(input reg_index_t index);
    if (index == '0) begin
      return '0;
    end else if (wb.write_enable && wb.rd == index) begin
      return wb.data;
    end
    return regs[index];
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.write_enable && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_comb rd_port.rs1_data = read_reg(rd_port.rs1_index);
  always_comb rd_port.rs2_data = read_reg(rd_port.rs2_index);

  // decode drops rd_valid for x0
  a_no_x0_write: assert property (
    @(posedge clock) disable iff (reset) wb.write_enable |-> wb.rd != '0
  ) else $error("write enable set with rd = x0");

endmodule

// ==== test/int_core_tb.sv ====
/*
  Table-driven testbench for int_core, register file empty at start.
  Expected values are hand computed; idle gaps are random, fixed seed.
*/
`timescale 1ns/1ps

module int_core_tb;
  import isa_pkg::*;

  logic       clock;
  logic       reset;
  inst_t      inst;
  logic       inst_valid;
  logic       retire_valid;
  logic       retire_illegal;
  reg_index_t retire_rd;
  xlen_t      retire_data;

  string      tbl_name [$];
  inst_t      tbl_inst [$];
  bit         tbl_illegal [$];
  reg_index_t tbl_rd [$];
  xlen_t      tbl_data [$];
  bit         tbl_b2b [$];
  // table indices in flight, oldest first
  int         pending [$];

  int pass_count = 0;
  int fail_count = 0;
  int cycle_count = 0;
  int timeout_limit = 1000;
  int seed = 32'h518f;
  int gap;
  int idx;
  bit ok;

  int_core u_int_core (
    .clock          (clock),
    .reset          (reset),
    .inst           (inst),
    .inst_valid     (inst_valid),
    .retire_valid   (retire_valid),
    .retire_illegal (retire_illegal),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  function automatic inst_t r_type(input logic [6:0] funct7, input reg_index_t rs2,
                                   input reg_index_t rs1, input logic [2:0] funct3,
                                   input reg_index_t rd);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic inst_t i_type(input logic [11:0] imm, input reg_index_t rs1,
                                   input logic [2:0] funct3, input reg_index_t rd);
    return {imm, rs1, funct3, rd, 7'b0010011};
  endfunction

  function automatic inst_t u_type(input logic [19:0] imm, input reg_index_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic add_case(input string name, input inst_t word, input reg_index_t rd,
                          input xlen_t data, input bit back_to_back);
    tbl_name.push_back(name);
    tbl_inst.push_back(word);
    tbl_illegal.push_back(1'b0);
    tbl_rd.push_back(rd);
    tbl_data.push_back(data);
    tbl_b2b.push_back(back_to_back);
  endtask

  task automatic add_illegal(input string name, input inst_t word, input bit back_to_back);
    add_case(name, word, 5'd0, '0, back_to_back);
    tbl_illegal[tbl_illegal.size()-1] = 1'b1;
  endtask

  task automatic check_retire(input reg_index_t exp_rd, input xlen_t exp_data, output bit pass);
    pass = 1'b1;
    if (retire_valid !== 1'b1 || retire_illegal !== 1'b0) begin
      $display("[ERROR] %0t flags valid=%b illegal=%b, expected a valid retirement",
               $time, retire_valid, retire_illegal);
      pass = 1'b0;
    end
    if (retire_rd !== exp_rd || retire_data !== exp_data) begin
      $display("[ERROR] %0t rd=%0d data=%h, expected rd=%0d data=%h",
               $time, retire_rd, retire_data, exp_rd, exp_data);
      pass = 1'b0;
    end
  endtask

  task automatic check_illegal(output bit pass);
    pass = (retire_illegal === 1'b1) && (retire_valid === 1'b0);
    if (!pass) begin
      $display("[ERROR] %0t flags valid=%b illegal=%b, expected an illegal retirement",
               $time, retire_valid, retire_illegal);
    end
  endtask

  task automatic build_table();
    add_case("add x3 before any write", r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 0, 0);
    add_case("addi x1,x0,-5", i_type(12'hFFB, 5'd0, 3'b000, 5'd1), 5'd1, 32'hFFFFFFFB, 0);
    add_case("addi x2,x0,0x123", i_type(12'h123, 5'd0, 3'b000, 5'd2), 5'd2, 32'h123, 0);
    add_case("xori x4,x2,0x0f0", i_type(12'h0F0, 5'd2, 3'b100, 5'd4), 5'd4, 32'h1D3, 0);
    add_case("ori x5,x2,0x404", i_type(12'h404, 5'd2, 3'b110, 5'd5), 5'd5, 32'h527, 0);
    add_case("andi x6,x1,0x0ff", i_type(12'h0FF, 5'd1, 3'b111, 5'd6), 5'd6, 32'hFB, 0);
    add_case("slti x7,x1,-4", i_type(12'hFFC, 5'd1, 3'b010, 5'd7), 5'd7, 1, 0);
    add_case("sltiu x8,x2,-1", i_type(12'hFFF, 5'd2, 3'b011, 5'd8), 5'd8, 1, 0);
    add_case("sltiu x9,x1,5", i_type(12'h005, 5'd1, 3'b011, 5'd9), 5'd9, 0, 0);
    add_case("lui x10,0x80001", u_type(20'h80001, 5'd10), 5'd10, 32'h80001000, 0);
    add_case("add x11,x1,x2", r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd11), 5'd11, 32'h11E, 0);
    add_case("sub x12,x0,x2", r_type(7'h20, 5'd2, 5'd0, 3'b000, 5'd12), 5'd12, 32'hFFFFFEDD, 0);
    add_case("slt x13,x1,x2", r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd13), 5'd13, 1, 0);
    add_case("sltu x14,x1,x2", r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd14), 5'd14, 0, 0);
    add_case("slt x15,x10,x1", r_type(7'h00, 5'd1, 5'd10, 3'b010, 5'd15), 5'd15, 1, 0);
    add_case("addi x16,x0,36", i_type(12'h024, 5'd0, 3'b000, 5'd16), 5'd16, 32'h24, 0);
    add_case("sll x17,x2,x16", r_type(7'h00, 5'd16, 5'd2, 3'b001, 5'd17), 5'd17, 32'h1230, 0);
    add_case("srl x18,x10,x16", r_type(7'h00, 5'd16, 5'd10, 3'b101, 5'd18), 5'd18,
             32'h08000100, 0);
    add_case("sra x19,x10,x16", r_type(7'h20, 5'd16, 5'd10, 3'b101, 5'd19), 5'd19,
             32'hF8000100, 0);
    add_case("slli x20,x2,8", i_type(12'h008, 5'd2, 3'b001, 5'd20), 5'd20, 32'h12300, 0);
    add_case("srli x21,x1,28", i_type(12'h01C, 5'd1, 3'b101, 5'd21), 5'd21, 32'hF, 0);
    add_case("srai x22,x1,1", i_type(12'h401, 5'd1, 3'b101, 5'd22), 5'd22, 32'hFFFFFFFD, 0);
    // dependent chain, no idle cycles between
    add_case("addi x23,x0,100", i_type(12'h064, 5'd0, 3'b000, 5'd23), 5'd23, 32'h64, 0);
    add_case("addi x24,x23,7", i_type(12'h007, 5'd23, 3'b000, 5'd24), 5'd24, 32'h6B, 1);
    add_case("add x25,x24,x23", r_type(7'h00, 5'd23, 5'd24, 3'b000, 5'd25), 5'd25, 32'hCF, 1);
    add_case("xor x26,x25,x24", r_type(7'h00, 5'd24, 5'd25, 3'b100, 5'd26), 5'd26, 32'hA4, 1);
    add_case("addi x0,x0,55", i_type(12'h037, 5'd0, 3'b000, 5'd0), 5'd0, 32'h37, 0);
    add_case("add x27,x0,x0", r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd27), 5'd27, 0, 1);
    add_case("or x28,x0,x0", r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd28), 5'd28, 0, 1);
    // lw x5,0(x2)
    add_illegal("lw x5 is illegal", 32'h00012283, 0);
    add_case("add x29,x5,x0", r_type(7'h00, 5'd0, 5'd5, 3'b000, 5'd29), 5'd29, 32'h527, 1);
    // funct7 of mul
    add_illegal("mul x6 is illegal", r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd6), 0);
    add_case("or x30,x6,x0", r_type(7'h00, 5'd0, 5'd6, 3'b110, 5'd30), 5'd30, 32'hFB, 0);
  endtask

  // retirements are popped in program order, mid-cycle
  always @(negedge clock) begin
    if (!reset && (retire_valid || retire_illegal)) begin
      if (pending.size() == 0) begin
        $display("unexpected retirement at %0t with no instruction outstanding", $time);
        fail_count++;
      end else begin
        idx = pending.pop_front();
        if (tbl_illegal[idx]) check_illegal(ok);
        else check_retire(tbl_rd[idx], tbl_data[idx], ok);
        $display("test %0d %s: %s", idx, tbl_name[idx], ok ? "ok" : "failed");
        if (ok) pass_count++;
        else fail_count++;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout after %0d cycles, %0d expected retirements never arrived",
               cycle_count, pending.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    inst = '0;
    inst_valid = 1'b0;
    build_table();
    timeout_limit = tbl_inst.size() * 3 + 20;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    // idle cycles, the monitor flags any retirement
    repeat (3) @(posedge clock);
    for (int i = 0; i < tbl_inst.size(); i++) begin
      gap = tbl_b2b[i] ? 0 : {$random(seed)} % 3;
      repeat (gap) begin
        @(posedge clock);
        inst <= '0;
        inst_valid <= 1'b0;
      end
      @(posedge clock);
      inst <= tbl_inst[i];
      inst_valid <= 1'b1;
      pending.push_back(i);
    end
    @(posedge clock);
    inst <= '0;
    inst_valid <= 1'b0;
    while (pending.size() != 0) @(posedge clock);
    repeat (3) @(posedge clock);
    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count == tbl_inst.size()) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/isa_pkg.sv
src/core_pkg.sv
src/core_ifs.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/int_core.sv
test/int_core_tb.sv
